// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= feBootTb
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== hdl/apbConsoleRegs.sv ====
`timescale 1ns/100ps

module apbConsoleRegs
  import klWordPkg::*;
  import ebusDiagPkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  logic        pSel,
  input  logic        pEnable,
  input  logic        pWrite,
  input  logic [7:0]  pAddr,
  input  logic [31:0] pWData,
  output logic [31:0] pRData,
  output logic        pReady,
  input  logic        busy,
  input  logic        loadDone,
  input  addrT        minAddr,
  input  addrT        maxAddr,
  input  wordT        startWord,
  output diagReqT     cmdReq,
  output logic        singleGo,
  output logic        resetGo,
  output logic        byteValid,
  output logic        restart,
  output fileByteT    byteIn
);

  logic access;
  logic ctrlWr;
  logic startsCmd;
  logic resetPending;
  logic resetDone;

  ////////////////////
  // Access decode

  assign access    = pSel && pEnable;
  assign ctrlWr    = access && pWrite && (pAddr == 8'h00);
  // Bit 0 is master reset, bit 1 is single function
  assign startsCmd = pWData[0] || pWData[1];

  // Stall a command write until the sequencer is free
  assign pReady    = !(ctrlWr && startsCmd && busy);

  // CTRL pulses only fire on the completing cycle
  assign resetGo   = ctrlWr && pReady && pWData[0];
  assign singleGo  = ctrlWr && pReady && pWData[1];
  assign restart   = ctrlWr && pReady && pWData[2];

  // BOOTBYTE goes straight to the packer
  assign byteValid = access && pWrite && (pAddr == 8'h08);
  assign byteIn    = pWData[7:0];

  // DIAGCMD register
  always_ff @(posedge CLK) begin
    if (access && pWrite && (pAddr == 8'h04)) begin
      cmdReq.func <= diagFuncT'(pWData[24:18]);
      cmdReq.rh   <= pWData[17:0];
    end
  end

  ////////////////////
  // Master reset done

  // Pending from the go pulse until busy drops again
  always_ff @(posedge CLK) begin
    if (reset) begin
      resetPending <= 1'b0;
      resetDone    <= 1'b0;
    end else if (resetGo) begin
      resetPending <= 1'b1;
      resetDone    <= 1'b0;
    end else if (resetPending && !busy) begin
      resetPending <= 1'b0;
      resetDone    <= 1'b1;
    end
  end

  ////////////////////
  // Read mux

  always_comb begin
    case (pAddr)
      8'h04:   pRData = {7'b0, cmdReq.func, cmdReq.rh};
      8'h0C:   pRData = {29'b0, resetDone, loadDone, busy};
      8'h10:   pRData = {14'b0, minAddr};
      8'h14:   pRData = {14'b0, maxAddr};
      8'h18:   pRData = {14'b0, startWord[0:17]};
      8'h1C:   pRData = {14'b0, startWord[18:35]};
      // CTRL and BOOTBYTE read as zero
      default: pRData = '0;
    endcase
  end

endmodule

// ==== hdl/diagCommandSeq.sv ====
`timescale 1ns/100ps

module diagCommandSeq
  import ebusDiagPkg::*;
(
  input  logic    CLK,
  input  logic    reset,
  input  diagReqT cmdReq,
  input  logic    singleGo,
  input  logic    resetGo,
  output logic    busy,
  output diagReqT fnReq,
  output logic    fnStart,
  input  logic    fnReady
);

  ////////////////////
  // Master reset list

  // Same order as the front end's reset routine
  localparam diagReqT ResetList [0:16] = '{
    '{clrRun,                  18'o000000},
    // External clock, no divider
    '{clrClkSrcRate,           18'o000010},
    '{stopClock,               18'o000000},
    '{setReset,                18'o000000},
    '{resetParRegs,            18'o000000},
    '{clrMboxdisParchkErrstop, 18'o000000},
    '{clrBurstCtrRh,           18'o000000},
    '{clrBurstCtrLh,           18'o000000},
    '{setEboxClkDisables,      18'o000000},
    '{startClock,              18'o000000},
    '{initChannels,            18'o000000},
    '{clrBurstCtrRh,           18'o000000},
    '{condStep,                18'o000000},
    '{clrReset,                18'o000000},
    '{enableKl,                18'o000000},
    '{ebusLoad,                18'o000000},
    // Memory reset through the MBOX
    '{writeMbox,               18'o000012}
  };

  seqStateT state;
  logic [4:0] stepIdx;
  // Host command captured at go, DIAGCMD may change meanwhile
  diagReqT singleCmd;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= seqIdle;
      stepIdx <= '0;
    end else begin
      case (state)
        seqIdle:
          // Master reset wins if both bits are written together
          if (resetGo) begin
            state   <= seqResetList;
            stepIdx <= '0;
          end else if (singleGo) begin
            state <= seqSingle;
          end
        seqSingle:
          if (fnReady) state <= seqWaitDone;
        seqResetList:
          if (fnReady) begin
            if (stepIdx == 5'd16) state <= seqWaitDone;
            else stepIdx <= stepIdx + 5'd1;
          end
        // Hold busy until the last recovery gap has passed
        seqWaitDone:
          if (fnReady) state <= seqIdle;
        default:
          state <= seqIdle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == seqIdle && singleGo) singleCmd <= cmdReq;
  end

  assign busy    = (state != seqIdle);
  assign fnStart = fnReady && (state == seqSingle || state == seqResetList);
  assign fnReq   = (state == seqSingle) ? singleCmd : ResetList[stepIdx];

endmodule

// ==== hdl/diagStrobeGen.sv ====
`timescale 1ns/100ps

module diagStrobeGen
  import ebusDiagPkg::*;
#(
  parameter int StrobeCycles   = 9,
  parameter int RecoveryCycles = 4
) (
  input  logic     CLK,
  input  logic     reset,
  input  diagReqT  fnReq,
  input  logic     fnStart,
  output logic     fnReady,
  output ebusDiagT ebusDiag
);

  // Wide enough for the longer of the two intervals
  localparam int MaxCycles  = (StrobeCycles > RecoveryCycles) ? StrobeCycles : RecoveryCycles;
  localparam int CountWidth = $clog2(MaxCycles + 1);

  strobeStateT state;
  logic [CountWidth-1:0] count;

  // New function accepted only between recovery gaps
  assign fnReady = (state == strobeIdle);

  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= strobeIdle;
      count    <= '0;
      ebusDiag <= EbusIdle;
    end else begin
      case (state)
        strobeIdle:
          if (fnStart) begin
            state    <= strobeHold;
            count    <= CountWidth'(StrobeCycles - 1);
            ebusDiag <= '{diagStrobe: 1'b1, func: fnReq.func, rh: fnReq.rh};
          end
        strobeHold:
          // Drop strobe, function and operand together
          if (count == '0) begin
            state    <= strobeRecover;
            count    <= CountWidth'(RecoveryCycles - 1);
            ebusDiag <= EbusIdle;
          end else begin
            count <= count - 1'b1;
          end
        strobeRecover:
          if (count == '0) state <= strobeIdle;
          else count <= count - 1'b1;
        default:
          state <= strobeIdle;
      endcase
    end
  end

endmodule

// ==== hdl/ebusDiagPkg.sv ====
package ebusDiagPkg;
  import klWordPkg::*;

  ////////////////////
  // Diagnostic functions

  // Codes are octal, as listed for the clock and reset logic
  typedef enum logic [6:0] {
    stopClock               = 7'o000,
    startClock              = 7'o001,
    stepClock               = 7'o002,
    condStep                = 7'o004,
    clrReset                = 7'o006,
    setReset                = 7'o007,
    clrRun                  = 7'o010,
    clrBurstCtrRh           = 7'o042,
    clrBurstCtrLh           = 7'o043,
    clrClkSrcRate           = 7'o044,
    setEboxClkDisables      = 7'o045,
    resetParRegs            = 7'o046,
    clrMboxdisParchkErrstop = 7'o047,
    enableKl                = 7'o067,
    initChannels            = 7'o070,
    writeMbox               = 7'o071,
    ebusLoad                = 7'o076,
    // Shown on the bus whenever no strobe is active
    idle                    = 7'o177
  } diagFuncT;

  // What the front end drives onto the diagnostic bus
  typedef struct packed {
    logic     diagStrobe;
    diagFuncT func;
    halfT     rh;
  } ebusDiagT;

  // Quiet bus, strobe low and no operand
  localparam ebusDiagT EbusIdle = '{diagStrobe: 1'b0, func: idle, rh: '0};

  // One requested function with its operand
  typedef struct packed {
    diagFuncT func;
    halfT     rh;
  } diagReqT;

  // One word written into processor memory
  typedef struct packed {
    logic valid;
    addrT addr;
    wordT data;
  } memWriteT;

  ////////////////////
  // State machines

  typedef enum logic [1:0] {seqIdle, seqSingle, seqResetList, seqWaitDone} seqStateT;

  typedef enum logic [1:0] {strobeIdle, strobeHold, strobeRecover} strobeStateT;

  typedef enum logic [1:0] {ldHeader, ldData, ldDone} loadStateT;

endpackage

// ==== hdl/exeWordPacker.sv ====
`timescale 1ns/100ps

module exeWordPacker
  import klWordPkg::*;
(
  input  logic     CLK,
  input  logic     reset,
  input  logic     restart,
  input  logic     byteValid,
  input  fileByteT byteIn,
  output wordT     word,
  output logic     wordValid
);

  // Position of the next byte within the five byte group
  logic [2:0] byteCnt;

  always_ff @(posedge CLK) begin
    if (reset || restart) begin
      byteCnt   <= '0;
      wordValid <= 1'b0;
    end else begin
      wordValid <= 1'b0;
      if (byteValid) begin
        if (byteCnt == 3'd4) begin
          byteCnt   <= '0;
          wordValid <= 1'b1;
        end else begin
          byteCnt <= byteCnt + 3'd1;
        end
      end
    end
  end

  // Big end first, fifth byte gives only its upper nibble
  always_ff @(posedge CLK) begin
    if (byteValid) begin
      case (byteCnt)
        3'd0:    word[0:7]   <= byteIn;
        3'd1:    word[8:15]  <= byteIn;
        3'd2:    word[16:23] <= byteIn;
        3'd3:    word[24:31] <= byteIn;
        default: word[32:35] <= byteIn[7:4];
      endcase
    end
  end

endmodule

// ==== hdl/feBootTop.sv ====
`timescale 1ns/100ps

module feBootTop
  import klWordPkg::*;
  import ebusDiagPkg::*;
#(
  parameter int StrobeCycles   = 9,
  parameter int RecoveryCycles = 4
) (
  input  logic        CLK,
  input  logic        reset,
  // Host side, APB slave
  input  logic        pSel,
  input  logic        pEnable,
  input  logic        pWrite,
  input  logic [7:0]  pAddr,
  input  logic [31:0] pWData,
  output logic [31:0] pRData,
  output logic        pReady,
  // Processor side
  output ebusDiagT    ebusDiag,
  output memWriteT    memWrite
);

  // Host register block to command sequencer
  diagReqT  cmdReq;
  logic     singleGo;
  logic     resetGo;
  logic     busy;

  // Command sequencer to strobe generator
  diagReqT  fnReq;
  logic     fnStart;
  logic     fnReady;

  // Image byte path
  fileByteT byteIn;
  logic     byteValid;
  logic     restart;
  wordT     word;
  logic     wordValid;

  // Loader results back to the host
  logic     loadDone;
  addrT     minAddr;
  addrT     maxAddr;
  wordT     startWord;

  apbConsoleRegs regs_i (.*);

  diagCommandSeq seq_i (.*);

  diagStrobeGen #(
    .StrobeCycles  (StrobeCycles),
    .RecoveryCycles(RecoveryCycles)
  ) strobe_i (.*);

  exeWordPacker packer_i (.*);

  iowdLoader loader_i (.*);

endmodule

// ==== hdl/iowdLoader.sv ====
`timescale 1ns/100ps

module iowdLoader
  import klWordPkg::*;
  import ebusDiagPkg::*;
(
  input  logic     CLK,
  input  logic     reset,
  input  logic     restart,
  input  logic     wordValid,
  input  wordT     word,
  output memWriteT memWrite,
  output logic     loadDone,
  output addrT     minAddr,
  output addrT     maxAddr,
  output wordT     startWord
);

  loadStateT state;
  // Data words still to come in this block
  halfT remain;
  // Next load address
  addrT loadAddr;
  logic memValid;
  addrT memAddr;
  wordT memData;

  ////////////////////
  // Block parser

  always_ff @(posedge CLK) begin
    if (reset || restart) begin
      state     <= ldHeader;
      remain    <= '0;
      loadAddr  <= '0;
      memValid  <= 1'b0;
      loadDone  <= 1'b0;
      minAddr   <= '1;
      maxAddr   <= '0;
      startWord <= '0;
    end else begin
      memValid <= 1'b0;
      if (wordValid) begin
        case (state)
          ldHeader:
            // Negative left half is an IOWD, count is its two's complement
            if (word[0]) begin
              remain   <= -word[0:17];
              loadAddr <= word[18:35];
              state    <= ldData;
            end else begin
              // Anything else ends the image with the start word
              startWord <= word;
              loadDone  <= 1'b1;
              state     <= ldDone;
            end
          ldData: begin
            memValid <= 1'b1;
            loadAddr <= loadAddr + 1'b1;
            if (loadAddr < minAddr) minAddr <= loadAddr;
            if (loadAddr > maxAddr) maxAddr <= loadAddr;
            remain <= remain - 1'b1;
            if (remain == 18'd1) state <= ldHeader;
          end
          // Trailing bytes after the start word are dropped
          default: ;
        endcase
      end
    end
  end

  // Write payload follows the data word
  always_ff @(posedge CLK) begin
    if (wordValid && state == ldData) begin
      memAddr <= loadAddr;
      memData <= word;
    end
  end

  assign memWrite = '{valid: memValid, addr: memAddr, data: memData};

endmodule

// ==== hdl/klWordPkg.sv ====
package klWordPkg;

  ////////////////////
  // Machine word types

  // Full 36-bit word
  // Bit 0 is the most significant bit, as the processor numbers it
  typedef logic [0:35] wordT;

  // Left or right half of a word
  // The left half is word bits 0 to 17, the right half bits 18 to 35
  typedef logic [0:17] halfT;

  // Physical memory address as carried in a right half
  typedef logic [0:17] addrT;

  ////////////////////
  // Image file types

  // One byte of the bootstrap image file
  // Five of these carry one word, the last one only half used
  typedef logic [7:0] fileByteT;

endpackage

// ==== testbench/feBootTasks.svh ====
`ifndef FE_BOOT_TASKS_SVH
`define FE_BOOT_TASKS_SVH

////////////////////
// Checking and APB access

task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
  if (actual !== expected) begin
    $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
             expected);
    $display("STATUS: FAIL");
    $fatal(1, "Value check failed");
  end
endtask

// Starts and ends on a falling edge with pReady sampled 1 ns later
task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
  pSel    = 1'b1;
  pEnable = 1'b0;
  pWrite  = 1'b1;
  pAddr   = addr;
  pWData  = data;
  @(negedge CLK);
  pEnable    = 1'b1;
  waitStates = 0;
  #1;
  while (!pReady) begin
    waitStates++;
    @(negedge CLK);
    #1;
  end
  busyAtAccept = dut_i.busy;
  @(negedge CLK);
  pSel      = 1'b0;
  pEnable   = 1'b0;
  pWrite    = 1'b0;
  // Rising edge on which the transfer completed
  doneCycle = cycleCnt;
endtask

task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
  pSel    = 1'b1;
  pEnable = 1'b0;
  pWrite  = 1'b0;
  pAddr   = addr;
  @(negedge CLK);
  pEnable = 1'b1;
  #1;
  while (!pReady) begin
    @(negedge CLK);
    #1;
  end
  data = pRData;
  @(negedge CLK);
  pSel    = 1'b0;
  pEnable = 1'b0;
endtask

// Big end first with random filler in the low nibble of the fifth byte
task automatic pushWord(input logic [35:0] w);
  apbWrite(8'h08, {24'b0, w[35:28]});
  apbWrite(8'h08, {24'b0, w[27:20]});
  apbWrite(8'h08, {24'b0, w[19:12]});
  apbWrite(8'h08, {24'b0, w[11:4]});
  apbWrite(8'h08, {24'b0, w[3:0], 4'($urandom)});
endtask

////////////////////
// Directed tests

task automatic resetState();
  logic [31:0] rd;
  apbRead(8'h0C, rd);
  checkValue(rd, 32'h0, "STATUS after reset");
  apbRead(8'h10, rd);
  checkValue(rd, 32'h0003_FFFF, "MINADDR after reset");
  apbRead(8'h14, rd);
  checkValue(rd, 32'h0, "MAXADDR after reset");
  apbRead(8'h18, rd);
  checkValue(rd, 32'h0, "STARTLH after reset");
  apbRead(8'h1C, rd);
  checkValue(rd, 32'h0, "STARTRH after reset");
  checkValue(ebusDiag.diagStrobe, 1'b0, "strobe after reset");
  checkValue(ebusDiag.func, 7'o177, "bus function after reset");
  checkValue(ebusDiag.rh, 18'o0, "bus rh after reset");
  checkValue(memWrite.valid, 1'b0, "memory write valid after reset");
endtask

task automatic singleDiag();
  logic [6:0]  func;
  logic [17:0] rh;
  logic [31:0] rd;
  int          goCycle;
  int          highCycles;
  func = ResetFuncs[$urandom % 17];
  rh   = 18'($urandom);
  apbWrite(8'h04, {7'b0, func, rh});
  apbRead(8'h04, rd);
  checkValue(rd, {7'b0, func, rh}, "DIAGCMD readback");
  apbWrite(8'h00, 32'h2);
  goCycle    = doneCycle;
  highCycles = 0;
  while (!ebusDiag.diagStrobe) @(negedge CLK);
  // Function and operand must hold for the whole strobe
  while (ebusDiag.diagStrobe) begin
    checkValue(ebusDiag.func, func, "function under strobe");
    checkValue(ebusDiag.rh, rh, "rh under strobe");
    highCycles++;
    @(negedge CLK);
  end
  checkValue(highCycles, StrobeCycles, "strobe length in cycles");
  checkValue(ebusDiag.func, 7'o177, "bus function after strobe");
  checkValue(ebusDiag.rh, 18'o0, "bus rh after strobe");
  while (dut_i.busy) @(negedge CLK);
  checkValue(cycleCnt - goCycle, StrobeCycles + RecoveryCycles + 2,
             "cycles from CTRL write to busy low");
endtask

task automatic masterReset();
  logic [31:0] rd;
  strobeLog.delete();
  apbWrite(8'h00, 32'h1);
  while (dut_i.busy) @(negedge CLK);
  checkValue(strobeLog.size(), 17, "functions issued by master reset");
  for (int i = 0; i < 17; i++) begin
    checkValue(strobeLog[i], {ResetFuncs[i], ResetRh[i]},
               $sformatf("master reset step %0d", i + 1));
  end
  // Only resetDone should be up
  apbRead(8'h0C, rd);
  checkValue(rd, 32'h4, "STATUS after master reset");
endtask

task automatic backPressure();
  logic [24:0] first;
  logic [24:0] second;
  first  = {ResetFuncs[$urandom % 17], 18'($urandom)};
  second = {ResetFuncs[$urandom % 17], 18'($urandom)};
  strobeLog.delete();
  apbWrite(8'h04, {7'b0, first});
  apbWrite(8'h00, 32'h2);
  // DIAGCMD may change while the first command runs
  apbWrite(8'h04, {7'b0, second});
  apbWrite(8'h00, 32'h2);
  checkValue(waitStates > 0, 1'b1, "second CTRL write held off");
  checkValue(busyAtAccept, 1'b0, "busy when second CTRL write completed");
  while (dut_i.busy) @(negedge CLK);
  checkValue(strobeLog.size(), 2, "functions issued under back-pressure");
  checkValue(strobeLog[0], first, "first queued function");
  checkValue(strobeLog[1], second, "second queued function");
endtask

task automatic bootLoad();
  logic [35:0] words [$];
  logic [53:0] expWrites [$];
  logic [35:0] data;
  logic [35:0] start;
  logic [17:0] addr;
  logic [17:0] minA;
  logic [17:0] maxA;
  logic [31:0] rd;
  int          len;
  minA = '1;
  maxA = '0;
  for (int b = 0; b < 2; b++) begin
    len  = 1 + ($urandom % 6);
    addr = 18'($urandom % 18'o700000);
    // IOWD header carries minus the word count in its left half
    words.push_back({18'(-len), addr});
    for (int i = 0; i < len; i++) begin
      data = {$urandom, 4'($urandom)};
      words.push_back(data);
      expWrites.push_back({addr, data});
      if (addr < minA) minA = addr;
      if (addr > maxA) maxA = addr;
      addr++;
    end
  end
  // Positive left half ends the image
  start = {1'b0, 17'($urandom), 18'($urandom)};
  words.push_back(start);
  writeLog.delete();
  apbWrite(8'h00, 32'h4);
  foreach (words[w]) pushWord(words[w]);
  checkValue(writeLog.size(), expWrites.size(), "number of memory writes");
  foreach (expWrites[i]) begin
    checkValue(writeLog[i], expWrites[i], $sformatf("memory write %0d", i));
  end
  // resetDone survives the loader restart
  apbRead(8'h0C, rd);
  checkValue(rd, 32'h6, "STATUS after load");
  apbRead(8'h10, rd);
  checkValue(rd, {14'b0, minA}, "MINADDR");
  apbRead(8'h14, rd);
  checkValue(rd, {14'b0, maxA}, "MAXADDR");
  apbRead(8'h18, rd);
  checkValue(rd, {14'b0, start[35:18]}, "STARTLH");
  apbRead(8'h1C, rd);
  checkValue(rd, {14'b0, start[17:0]}, "STARTRH");
  // Restart clears the loader results
  apbWrite(8'h00, 32'h4);
  apbRead(8'h0C, rd);
  checkValue(rd, 32'h4, "STATUS after loader restart");
  apbRead(8'h10, rd);
  checkValue(rd, 32'h0003_FFFF, "MINADDR after loader restart");
endtask

`endif

// ==== testbench/feBootTb.sv ====
`timescale 1ns/100ps

module feBootTb
  import klWordPkg::*;
  import ebusDiagPkg::*;
();

  localparam int ClkPeriod      = 4;
  localparam int StrobeCycles   = 9;
  localparam int RecoveryCycles = 4;
  localparam int unsigned Seed  = 32'h0b51b27a;
  // Covers reset, three single commands, the 17 step list and up to 75 byte pushes
  localparam int TestCycles     = 600;

  // Master reset list with function codes in octal
  localparam logic [6:0] ResetFuncs [0:16] = '{
    7'o010, 7'o044, 7'o000, 7'o007, 7'o046, 7'o047, 7'o042, 7'o043, 7'o045,
    7'o001, 7'o070, 7'o042, 7'o004, 7'o006, 7'o067, 7'o076, 7'o071
  };
  // Operands are zero except the clock source rate and the MBOX write
  localparam logic [17:0] ResetRh [0:16] = '{
    18'o0, 18'o10, 18'o0, 18'o0, 18'o0, 18'o0, 18'o0, 18'o0, 18'o0,
    18'o0, 18'o0, 18'o0, 18'o0, 18'o0, 18'o0, 18'o0, 18'o12
  };

  logic        CLK;
  logic        reset;
  logic        pSel;
  logic        pEnable;
  logic        pWrite;
  logic [7:0]  pAddr;
  logic [31:0] pWData;
  logic [31:0] pRData;
  logic        pReady;
  ebusDiagT    ebusDiag;
  memWriteT    memWrite;

  // Posedge count read on falling edges
  int          cycleCnt;
  // Results of the last APB write
  int          waitStates;
  int          doneCycle;
  logic        busyAtAccept;

  // Func and rh at each strobe rise
  logic [24:0] strobeLog [$];
  logic        strobeWasHigh;
  // Addr and data of each memory write
  logic [53:0] writeLog [$];

  `include "feBootTasks.svh"

  feBootTop dut_i (
    .CLK     (CLK),
    .reset   (reset),
    .pSel    (pSel),
    .pEnable (pEnable),
    .pWrite  (pWrite),
    .pAddr   (pAddr),
    .pWData  (pWData),
    .pRData  (pRData),
    .pReady  (pReady),
    .ebusDiag(ebusDiag),
    .memWrite(memWrite)
  );

  always #(ClkPeriod / 2) CLK = ~CLK;

  always @(posedge CLK) cycleCnt <= cycleCnt + 1;

  ////////////////////
  // Bus monitors

  // Sampled on the falling edge while DUT outputs are stable
  always @(negedge CLK) begin
    if (ebusDiag.diagStrobe && !strobeWasHigh) begin
      strobeLog.push_back({ebusDiag.func, ebusDiag.rh});
    end
    strobeWasHigh = ebusDiag.diagStrobe;
    if (memWrite.valid) writeLog.push_back({memWrite.addr, memWrite.data});
  end

  // Watchdog allows twice the expected run length
  initial begin
    #(2 * TestCycles * ClkPeriod);
    $display("Watchdog expired: tests did not finish within %0d cycles", 2 * TestCycles);
    $display("STATUS: FAIL");
    $fatal(1, "Run aborted by watchdog");
  end

  ////////////////////
  // Test order

  initial begin
    void'($urandom(Seed));
    CLK           = 1'b0;
    reset         = 1'b1;
    pSel          = 1'b0;
    pEnable       = 1'b0;
    pWrite        = 1'b0;
    pAddr         = '0;
    pWData        = '0;
    cycleCnt      = 0;
    strobeWasHigh = 1'b0;
    repeat (16) @(negedge CLK);
    reset = 1'b0;
    @(negedge CLK);
    resetState();
    singleDiag();
    masterReset();
    backPressure();
    bootLoad();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+testbench
hdl/klWordPkg.sv
hdl/ebusDiagPkg.sv
hdl/apbConsoleRegs.sv
hdl/diagCommandSeq.sv
hdl/diagStrobeGen.sv
hdl/exeWordPacker.sv
hdl/iowdLoader.sv
hdl/feBootTop.sv
testbench/feBootTb.sv
